/* uartLink.f */
hw/uartPkg.sv
hw/syncFifo.sv
hw/uartTx.sv
hw/uartRx.sv
hw/rxDelivery.sv
hw/uartLink.sv
tests/uartLinkTb.sv

/* build.sh */
#!/bin/sh
# Build and run the uartLink regression with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing \
	-f uartLink.f \
	--top-module uartLinkTb \
	-o uartLinkSim

./obj_dir/uartLinkSim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

/* tests/uartGolden.txt */
# mode (0 loopback, 1 inject, 2 back-pressure) byte parityFlip stopPattern
# expectedData expectedErrorCode, all hex
0 a5 0 3 a5 0
0 3c 0 3 3c 0
0 00 0 3 00 0
0 ff 0 3 ff 0
0 81 0 3 81 0
0 7e 0 3 7e 0
1 5a 1 3 00 2
1 96 0 1 00 4
1 00 0 0 00 5
1 c3 0 3 c3 0
1 00 0 2 00 5
1 7f 1 0 00 6
1 00 1 0 00 7
2 11 0 3 11 0
2 22 0 3 22 0
2 33 0 3 33 0
2 44 0 3 44 0
2 55 0 3 55 0
2 66 0 3 66 0

/* tests/uartLinkTb.sv */
`timescale 1ns/1ps

module uartLinkTb import uartPkg::*; ();

	localparam int WAIT_LIMIT = 2000;
	localparam int STALL_CYCLES = 26; // two frame lengths

	logic Clk;
	logic Rst;
	logic TxValid;
	logic [DATA_BITS-1:0] TxData;
	logic Cts;
	logic RxLine;
	logic RxCredit;
	logic TxCredit;
	logic TxLine;
	logic Rts;
	logic RxValid;
	logic [DATA_BITS-1:0] RxData;
	logic [ERR_BITS-1:0] RxError;

	logic loopback;
	logic injLine;
	logic [31:0] lfsr;
	int hostCredits;
	int creditPulses;
	int bytesSent;
	int granted;
	int errors;
	int timeouts;

	logic [7:0] vMode[$];
	logic [7:0] vByte[$];
	logic [7:0] vFlip[$];
	logic [7:0] vStop[$];
	logic [7:0] vData[$];
	logic [7:0] vErr[$];
	logic [DATA_BITS-1:0] gotData[$];
	logic [ERR_BITS-1:0] gotErr[$];

	assign RxLine = loopback ? TxLine : injLine;
	assign Cts = loopback ? Rts : 1'b0; // transmitter held off while injecting

	uartLink DUT (
		.Clk(Clk),
		.Rst(Rst),
		.TxValid(TxValid),
		.TxData(TxData),
		.Cts(Cts),
		.RxLine(RxLine),
		.RxCredit(RxCredit),
		.TxCredit(TxCredit),
		.TxLine(TxLine),
		.Rts(Rts),
		.RxValid(RxValid),
		.RxData(RxData),
		.RxError(RxError)
	);

	initial
	begin
		Clk = 1'b0;
		forever #50 Clk = ~Clk;
	end

	// ==============================
	// helpers
	// ==============================
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic takeBits(input int n, output int v);
		v = 0;
		repeat (n)
		begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsrNext(lfsr);
		end
	endtask

	task automatic step();
		@(posedge Clk);
		#1;
	endtask

	task automatic hostSend(input logic [7:0] b);
		int t;
		t = 0;
		while (hostCredits == 0 && t < WAIT_LIMIT)
		begin
			step();
			t++;
		end
		if (hostCredits == 0)
		begin
			$display("timeout: no transmit credit came back for byte %h", b);
			timeouts++;
		end
		else
		begin
			TxValid = 1'b1;
			TxData = b;
			hostCredits--;
			bytesSent++;
			step();
			TxValid = 1'b0;
		end
	endtask

	// keeps outstanding grants within the credit counter's range
	task automatic grantCredits(input int cnt);
		int gap;
		int t;
		repeat (cnt)
		begin
			takeBits(2, gap);
			repeat (gap) step();
			t = 0;
			while ((granted - gotData.size()) >= RX_DEPTH && t < WAIT_LIMIT)
			begin
				step();
				t++;
			end
			if (t >= WAIT_LIMIT)
			begin
				$display("timeout: receive credits were never used up");
				timeouts++;
			end
			RxCredit = 1'b1;
			granted++;
			step();
			RxCredit = 1'b0;
		end
	endtask

	task automatic waitWords(input int total);
		int t;
		t = 0;
		while (gotData.size() < total && t < WAIT_LIMIT)
		begin
			step();
			t++;
		end
		if (gotData.size() < total)
		begin
			$display("timeout: only %0d of %0d words were delivered", gotData.size(), total);
			timeouts++;
		end
	endtask

	task automatic checkWord(input string name, input int k, input int v);
		logic [DATA_BITS-1:0] expD;
		logic [ERR_BITS-1:0] expE;
		expD = vData[v];
		expE = vErr[v][ERR_BITS-1:0];
		if (k < gotData.size())
		begin
			assert (gotData[k] == expD)
			else
			begin
				$display("FAIL %s data: expected %h, actual %h", name, expD, gotData[k]);
				errors++;
			end
			assert (gotErr[k] == expE)
			else
			begin
				$display("FAIL %s error code: expected %0d, actual %0d", name, expE, gotErr[k]);
				errors++;
			end
		end
	endtask

	task automatic injectFrame(input logic [7:0] b, input logic flip, input logic [1:0] stop);
		injLine = 1'b0; // start bit
		step();
		for (int i = DATA_BITS - 1; i >= 0; i--)
		begin
			injLine = b[i];
			step();
		end
		injLine = (^b) ^ flip;
		step();
		for (int i = STOP_BITS - 1; i >= 0; i--)
		begin
			injLine = stop[i];
			step();
		end
		injLine = 1'b1;
		step();
	endtask

	task automatic readGolden();
		int fd;
		int n;
		logic [8*120-1:0] line;
		logic [7:0] f[6];
		fd = $fopen("tests/uartGolden.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the golden vector file");
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = '0;
			if ($fgets(line, fd) != 0)
			begin
				n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
				if (n == 6) // comment lines fail to scan
				begin
					vMode.push_back(f[0]);
					vByte.push_back(f[1]);
					vFlip.push_back(f[2]);
					vStop.push_back(f[3]);
					vData.push_back(f[4]);
					vErr.push_back(f[5]);
				end
			end
		end
		$fclose(fd);
	endtask

	// ==============================
	// monitor
	// ==============================
	always @(posedge Clk)
	begin
		if (!Rst)
		begin
			if (RxValid)
			begin
				gotData.push_back(RxData);
				gotErr.push_back(RxError);
			end
			if (TxCredit)
			begin
				hostCredits++;
				creditPulses++;
				assert (hostCredits <= TX_DEPTH)
				else
				begin
					$display("transmit credits returned beyond the queue depth");
					errors++;
				end
			end
		end
	end

	// ==============================
	// main sequence
	// ==============================
	initial
	begin
		int base;
		int stall;
		int t;
		int pulsesBase;
		int idx[$];
		Rst = 1'b1;
		TxValid = 1'b0;
		TxData = '0;
		RxCredit = 1'b0;
		loopback = 1'b1;
		injLine = 1'b1;
		lfsr = 32'hd1744208;
		hostCredits = TX_DEPTH;
		creditPulses = 0;
		bytesSent = 0;
		granted = 0;
		errors = 0;
		timeouts = 0;
		readGolden();
		repeat (4) @(posedge Clk);
		#1;
		Rst = 1'b0;
		step();
		assert (TxLine === 1'b1 && Rts === 1'b1 && RxValid === 1'b0 && TxCredit === 1'b0)
		else
		begin
			$display("FAIL reset {TxLine, Rts, RxValid, TxCredit}: expected 1100, actual %b%b%b%b",
				TxLine, Rts, RxValid, TxCredit);
			errors++;
		end

		// loopback with randomly spaced consumer credits
		for (int i = 0; i < vMode.size(); i++)
			if (vMode[i] == 8'h0)
				idx.push_back(i);
		base = gotData.size();
		fork
			foreach (idx[k]) hostSend(vByte[idx[k]]);
			grantCredits(idx.size());
		join
		waitWords(base + idx.size());
		foreach (idx[k]) checkWord("loopback", base + k, idx[k]);

		// injected frames with parity and stop faults
		loopback = 1'b0;
		for (int i = 0; i < vMode.size(); i++)
		begin
			if (vMode[i] == 8'h1)
			begin
				base = gotData.size();
				injectFrame(vByte[i], vFlip[i][0], vStop[i][1:0]);
				grantCredits(1);
				waitWords(base + 1);
				checkWord("inject", base, i);
			end
		end

		// back-pressure with credits withheld
		loopback = 1'b1;
		idx.delete();
		for (int i = 0; i < vMode.size(); i++)
			if (vMode[i] == 8'h2)
				idx.push_back(i);
		base = gotData.size();
		pulsesBase = creditPulses;
		foreach (idx[k]) hostSend(vByte[idx[k]]);
		stall = 0;
		t = 0;
		while (stall < STALL_CYCLES && t < WAIT_LIMIT)
		begin
			step();
			t++;
			if (!Rts && TxLine && !TxCredit)
				stall++;
			else
				stall = 0;
		end
		if (stall < STALL_CYCLES)
		begin
			$display("timeout: link never stalled with the receive queue full");
			timeouts++;
		end
		assert (gotData.size() == base)
		else
		begin
			$display("FAIL backpressure words without credit: expected 0, actual %0d",
				gotData.size() - base);
			errors++;
		end
		// the receive queue takes exactly RX_DEPTH frames before Rts drops
		assert (creditPulses - pulsesBase == RX_DEPTH)
		else
		begin
			$display("FAIL backpressure frames before stall: expected %0d, actual %0d",
				RX_DEPTH, creditPulses - pulsesBase);
			errors++;
		end
		grantCredits(idx.size());
		waitWords(base + idx.size());
		foreach (idx[k]) checkWord("backpressure", base + k, idx[k]);

		repeat (4) step();
		assert (creditPulses == bytesSent)
		else
		begin
			$display("FAIL credits returned: expected %0d, actual %0d", bytesSent, creditPulses);
			errors++;
		end

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* hw/uartLink.sv */
`timescale 1ns/1ps

module uartLink import uartPkg::*; (
	input logic Clk,
	input logic Rst,
	input logic TxValid,
	input logic [DATA_BITS-1:0] TxData,
	input logic Cts,
	input logic RxLine,
	input logic RxCredit,
	output logic TxCredit,
	output logic TxLine,
	output logic Rts,
	output logic RxValid,
	output logic [DATA_BITS-1:0] RxData,
	output logic [ERR_BITS-1:0] RxError
);

	logic [DATA_BITS-1:0] txQData;
	logic txQEmpty;
	logic txPop;
	logic rxPush;
	logic [RX_WORD_BITS-1:0] rxWord;
	logic rxQFull;

	// ==============================
	// transmit path
	// ==============================
	// host credits keep this queue from overflowing
	syncFifo #(
		.WIDTH(DATA_BITS),
		.DEPTH(TX_DEPTH)
	) txQueue (
		.Clk(Clk),
		.Rst(Rst),
		.Push(TxValid),
		.PushData(TxData),
		.Pop(txPop),
		.PopData(txQData),
		.Full(),
		.Empty(txQEmpty)
	);

	uartTx tx (
		.Clk(Clk),
		.Rst(Rst),
		.Cts(Cts),
		.QueueEmpty(txQEmpty),
		.QueueData(txQData),
		.QueuePop(txPop),
		.TxLine(TxLine)
	);

	assign TxCredit = txPop; // a byte leaving the queue frees one credit

	// ==============================
	// receive path
	// ==============================
	uartRx rx (
		.Clk(Clk),
		.Rst(Rst),
		.RxLine(RxLine),
		.QueueFull(rxQFull),
		.Rts(Rts),
		.QueuePush(rxPush),
		.QueueWord(rxWord)
	);

	rxDelivery delivery (
		.Clk(Clk),
		.Rst(Rst),
		.Push(rxPush),
		.PushWord(rxWord),
		.RxCredit(RxCredit),
		.Full(rxQFull),
		.RxValid(RxValid),
		.RxData(RxData),
		.RxError(RxError)
	);

endmodule

/* hw/rxDelivery.sv */
`timescale 1ns/1ps

module rxDelivery import uartPkg::*; (
	input logic Clk,
	input logic Rst,
	input logic Push,
	input logic [RX_WORD_BITS-1:0] PushWord,
	input logic RxCredit,
	output logic Full,
	output logic RxValid,
	output logic [DATA_BITS-1:0] RxData,
	output logic [ERR_BITS-1:0] RxError
);

	logic [RX_WORD_BITS-1:0] headWord;
	logic empty;
	logic pop;
	logic [RX_CREDIT_BITS-1:0] creditCnt;

	syncFifo #(
		.WIDTH(RX_WORD_BITS),
		.DEPTH(RX_DEPTH)
	) rxQueue (
		.Clk(Clk),
		.Rst(Rst),
		.Push(Push),
		.PushData(PushWord),
		.Pop(pop),
		.PopData(headWord),
		.Full(Full),
		.Empty(empty)
	);

	assign pop = (creditCnt != '0) && !empty; // one word per credit

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			creditCnt <= '0;
			RxValid <= 1'b0;
		end
		else
		begin
			RxValid <= pop;
			case ({RxCredit, pop})
				2'b10:
					if (creditCnt != RX_CREDIT_BITS'(RX_DEPTH))
						creditCnt <= creditCnt + 1'b1; // saturates at RX_DEPTH
				2'b01: creditCnt <= creditCnt - 1'b1;
				default: creditCnt <= creditCnt;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (pop)
		begin
			RxData <= headWord[DATA_BITS-1:0];
			RxError <= headWord[RX_WORD_BITS-1:DATA_BITS];
		end
	end

endmodule

/* hw/uartRx.sv */
`timescale 1ns/1ps

module uartRx import uartPkg::*; (
	input logic Clk,
	input logic Rst,
	input logic RxLine,
	input logic QueueFull,
	output logic Rts,
	output logic QueuePush,
	output logic [RX_WORD_BITS-1:0] QueueWord
);

	rxState state;
	rxState nextState;
	logic [BIT_CNT_BITS-1:0] bitCnt;
	logic [DATA_BITS-1:0] dataReg;
	logic [STOP_BITS-1:0] stopReg;
	logic parityBit;
	logic [ERR_BITS-1:0] errCode;
	logic framingErr;

	// ==============================
	// state sequence
	// ==============================
	always_comb
	begin
		nextState = state;
		case (state)
			rxReady:
				if (!RxLine)
					nextState = rxStart; // start bit seen
			rxStart: nextState = rxData;
			rxData:
				if (bitCnt == BIT_CNT_BITS'(DATA_BITS - 1))
					nextState = rxParity;
			rxParity: nextState = rxStop;
			rxStop:
				if (bitCnt == BIT_CNT_BITS'(STOP_BITS - 1))
					nextState = rxDone;
			rxDone: nextState = rxReady;
			default: nextState = rxReady;
		endcase
	end

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state <= rxReady;
			bitCnt <= '0;
		end
		else
		begin
			state <= nextState;
			case (state)
				rxStart: bitCnt <= BIT_CNT_BITS'(1); // first data bit taken here
				rxData:
					if (nextState == rxParity)
						bitCnt <= '0;
					else
						bitCnt <= bitCnt + 1'b1;
				rxStop:
					if (nextState == rxDone)
						bitCnt <= '0;
					else
						bitCnt <= bitCnt + 1'b1;
				default: bitCnt <= '0;
			endcase
		end
	end

	// one sample per clock, no oversampling
	always_ff @(posedge Clk)
	begin
		if ((state == rxStart) || (state == rxData))
			dataReg <= {dataReg[DATA_BITS-2:0], RxLine}; // msb arrives first
		if (state == rxParity)
			parityBit <= RxLine;
		if (state == rxStop)
			stopReg <= (stopReg << 1) | STOP_BITS'(RxLine);
	end

	// ==============================
	// error check and queue write
	// ==============================
	assign framingErr = (stopReg != '1);

	always_comb
	begin
		errCode = '0;
		errCode[ERR_FRAMING] = framingErr;
		errCode[ERR_PARITY] = (parityBit != ^dataReg);
		errCode[ERR_BREAK] = (dataReg == '0) && framingErr;
	end

	assign QueueWord = {errCode, (|errCode) ? {DATA_BITS{1'b0}} : dataReg};

	// a frame that finishes against a full queue is dropped
	assign QueuePush = (state == rxDone) && !QueueFull;
	assign Rts = (state == rxReady) && !QueueFull;

endmodule

/* hw/uartTx.sv */
`timescale 1ns/1ps

module uartTx import uartPkg::*; (
	input logic Clk,
	input logic Rst,
	input logic Cts,
	input logic QueueEmpty,
	input logic [DATA_BITS-1:0] QueueData,
	output logic QueuePop,
	output logic TxLine
);

	txState state;
	logic [BIT_CNT_BITS-1:0] bitCnt;
	logic [DATA_BITS-1:0] shiftReg;
	logic parityAcc;

	// a frame only starts from idle with the partner ready
	assign QueuePop = (state == txIdle) && Cts && !QueueEmpty;

	// the state names the bit that is on the line in this cycle
	always_comb
	begin
		case (state)
			txIdle: TxLine = 1'b1;
			txStart: TxLine = 1'b0;
			txData: TxLine = shiftReg[DATA_BITS-1]; // msb first
			txParity: TxLine = parityAcc;
			txStop: TxLine = 1'b1;
			default: TxLine = 1'b1;
		endcase
	end

	// ==============================
	// frame sequencing
	// ==============================
	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			state <= txIdle;
			bitCnt <= '0;
		end
		else
		begin
			case (state)
				txIdle:
				begin
					bitCnt <= '0;
					if (QueuePop)
						state <= txStart;
				end
				txStart:
				begin
					state <= txData;
					bitCnt <= '0;
				end
				txData:
				begin
					if (bitCnt == BIT_CNT_BITS'(DATA_BITS - 1))
					begin
						state <= txParity;
						bitCnt <= '0;
					end
					else
						bitCnt <= bitCnt + 1'b1;
				end
				txParity: state <= txStop;
				txStop:
				begin
					if (bitCnt == BIT_CNT_BITS'(STOP_BITS - 1))
					begin
						state <= txIdle; // one idle bit before the next pop
						bitCnt <= '0;
					end
					else
						bitCnt <= bitCnt + 1'b1;
				end
				default: state <= txIdle;
			endcase
		end
	end

	always_ff @(posedge Clk)
	begin
		if (QueuePop)
		begin
			shiftReg <= QueueData;
			parityAcc <= 1'b0;
		end
		else if (state == txData)
		begin
			parityAcc <= parityAcc ^ shiftReg[DATA_BITS-1]; // even parity
			shiftReg <= {shiftReg[DATA_BITS-2:0], 1'b0};
		end
	end

endmodule

/* hw/syncFifo.sv */
`timescale 1ns/1ps

module syncFifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input logic Clk,
	input logic Rst,
	input logic Push,
	input logic [WIDTH-1:0] PushData,
	input logic Pop,
	output logic [WIDTH-1:0] PopData,
	output logic Full,
	output logic Empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic doPush;
	logic doPop;

	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign Full = (count == CNT_W'(DEPTH));
	assign Empty = (count == '0);
	assign doPush = Push && !Full; // writes into a full buffer are ignored
	assign doPop = Pop && !Empty;
	assign PopData = mem[rdPtr]; // head entry, always visible

	always_ff @(posedge Clk)
	begin
		if (doPush)
			mem[wrPtr] <= PushData;
	end

	always_ff @(posedge Clk or posedge Rst)
	begin
		if (Rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count; // idle or push and pop together
			endcase
		end
	end

endmodule

/* hw/uartPkg.sv */
package uartPkg;

	// ==============================
	// frame format
	// ==============================
	localparam int DATA_BITS = 8;
	localparam int STOP_BITS = 2;
	localparam int BIT_CNT_BITS = $clog2(DATA_BITS);

	localparam int ERR_BITS = 3;
	localparam int ERR_BREAK = 0;
	localparam int ERR_PARITY = 1;
	localparam int ERR_FRAMING = 2;

	localparam int RX_WORD_BITS = ERR_BITS + DATA_BITS; // {error code, data}

	// ==============================
	// queues and credits
	// ==============================
	localparam int TX_DEPTH = 4;
	localparam int RX_DEPTH = 4;
	localparam int RX_CREDIT_BITS = $clog2(RX_DEPTH + 1);

	typedef enum logic [2:0] {
		rxReady,
		rxStart,
		rxData,
		rxParity,
		rxStop,
		rxDone
	} rxState;

	typedef enum logic [2:0] {
		txIdle,
		txStart,
		txData,
		txParity,
		txStop
	} txState;

endpackage
